// ==== files.f ====
mini_mcu_pkg.sv
obi_demux.sv
obi_resp_mux.sv
ram_bank.sv
ao_peripheral.sv
mini_mcu.sv
mini_mcu_properties.sv
tb_mini_mcu.sv

// ==== tb_mini_mcu.sv ====
// Self-checking testbench for mini_mcu with default parameters (4 banks of 256 words)
// random stimulus from a fixed seed, expected responses from a local model
`default_nettype none

module tb_mini_mcu;
  import mini_mcu_pkg::*;

  localparam int NUM_WORDS  = 4 * 256;
  localparam int BANK_WORDS = 256;
  localparam logic [31:0] RAM_BYTES = 32'(NUM_WORDS * 4);
  // about 700 transactions at up to 3 cycles each, plus margin
  localparam int MAX_CYCLES = 3000;

  typedef struct packed {
    logic        err;
    logic [31:0] rdata;
  } exp_resp_t;

  logic        clk;
  logic        arst_n;
  obi_req_t    bus_req;
  obi_resp_t   bus_resp;
  logic        boot_select;
  logic [31:0] exit_value;
  logic        exit_valid;

  exp_resp_t   exp_q[$];
  exp_resp_t   exp_head;
  logic [31:0] mem_model [NUM_WORDS];
  bit          written [NUM_WORDS];
  int          written_idx[$];
  logic [31:0] scratch_model;
  logic [31:0] exit_value_model;
  logic        strap_model;
  logic        accepted_q;
  integer      seed;
  int          cycles;
  int          n_checks;
  int          n_errors;
  int          err_mark;

  mini_mcu dut_i (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .bus_req_i    (bus_req),
    .bus_resp_o   (bus_resp),
    .boot_select_i(boot_select),
    .exit_value_o (exit_value),
    .exit_valid_o (exit_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] merge_lanes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] be);
    logic [31:0] res;
    for (int i = 0; i < 4; i++) begin
      res[8*i+:8] = be[i] ? new_w[8*i+:8] : old_w[8*i+:8];
    end
    return res;
  endfunction

  // first and last word of each bank, i in 0..7
  function automatic logic [31:0] boundary_addr(int i);
    return 32'((i / 2) * BANK_WORDS * 4 + (i % 2) * (BANK_WORDS * 4 - 4));
  endfunction

  task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (act === exp) else begin
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, sig, exp, act);
      n_errors++;
    end
  endtask

  // update the model in issue order and queue the response it predicts
  task automatic issue_request(input logic we, input logic [3:0] be, input logic [31:0] addr,
                               input logic [31:0] wdata);
    exp_resp_t exp;
    int        idx;
    exp = '0;
    if (addr < RAM_BYTES) begin
      idx = int'(addr >> 2);
      if (we) begin
        mem_model[idx] = merge_lanes(mem_model[idx], wdata, be);
        if (!written[idx]) begin
          written[idx] = 1'b1;
          written_idx.push_back(idx);
        end
      end else begin
        exp.rdata = mem_model[idx];
      end
    end else if (addr - AO_PERIPH_BASE_ADDR < AO_PERIPH_SIZE) begin
      if (we && addr[11:0] == EXIT_VALUE_OFFSET)
        exit_value_model = merge_lanes(exit_value_model, wdata, be);
      else if (we && addr[11:0] == SCRATCH_OFFSET)
        scratch_model = merge_lanes(scratch_model, wdata, be);
      else if (!we && addr[11:0] == EXIT_VALUE_OFFSET)
        exp.rdata = exit_value_model;
      else if (!we && addr[11:0] == SCRATCH_OFFSET)
        exp.rdata = scratch_model;
      else if (!we && addr[11:0] == BOOT_SELECT_OFFSET)
        exp.rdata = {31'b0, strap_model};
    end else begin
      exp.err = 1'b1;
    end
    @(posedge clk);
    bus_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    exp_q.push_back(exp);
  endtask

  // kinds: 0 RAM write, 1 RAM read of a written word, 2 scratch, 3 unmapped
  // unmapped addresses keep the low bits of a bank boundary word
  task automatic issue_random(input int kind);
    logic [31:0] a;
    logic [3:0]  be;
    int          w;
    be = 4'($random(seed));
    case (kind)
      0: begin
        w = $unsigned($random(seed)) % NUM_WORDS;
        issue_request(1'b1, written[w] ? be : 4'hf, 32'(w) << 2, $random(seed));
      end
      1: begin
        w = written_idx[$unsigned($random(seed)) % written_idx.size()];
        issue_request(1'b0, 4'hf, 32'(w) << 2, '0);
      end
      2: issue_request(1'($random(seed)), be, AO_PERIPH_BASE_ADDR + SCRATCH_OFFSET,
                       $random(seed));
      default: begin
        do
          a = ($random(seed) & ~32'hfff) | boundary_addr($unsigned($random(seed)) % 8);
        while (a < RAM_BYTES || a - AO_PERIPH_BASE_ADDR < AO_PERIPH_SIZE);
        issue_request(1'($random(seed)), be, a, $random(seed));
      end
    endcase
  endtask

  task automatic drain();
    @(posedge clk);
    bus_req <= '0;
    while (exp_q.size() != 0)
      @(posedge clk);
  endtask

  task automatic report_test(input string name);
    $display("test %-14s %s, %0d errors", name,
             (n_errors == err_mark) ? "passed" : "failed", n_errors - err_mark);
    err_mark = n_errors;
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      accepted_q <= 1'b0;
    else
      accepted_q <= bus_req.req && bus_resp.gnt;
  end

  // responses sampled mid-cycle, one cycle after acceptance and in order
  always @(negedge clk) begin
    if (arst_n) begin
      check_value("bus_resp_o.gnt", 32'(bus_req.req), 32'(bus_resp.gnt));
      check_value("bus_resp_o.rvalid", 32'(accepted_q), 32'(bus_resp.rvalid));
      if (bus_resp.rvalid) begin
        assert (exp_q.size() != 0) else begin
          $display("[ERROR] t=%0t a response came with no request outstanding", $time);
          n_errors++;
        end
        if (exp_q.size() != 0) begin
          exp_head = exp_q.pop_front();
          check_value("bus_resp_o.rdata", exp_head.rdata, bus_resp.rdata);
          check_value("bus_resp_o.err", 32'(exp_head.err), 32'(bus_resp.err));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    seed = 32'h390e;
    arst_n = 1'b0;
    bus_req = '0;
    boot_select = 1'b0;
    strap_model = 1'b0;
    scratch_model = '0;
    exit_value_model = '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("exit_valid_o", 32'(1'b0), 32'(exit_valid));
    check_value("exit_value_o", 32'h0, exit_value);
    issue_request(1'b0, 4'hf, AO_PERIPH_BASE_ADDR + SCRATCH_OFFSET, '0);
    drain();
    report_test("reset_state");

    repeat (400) begin
      issue_random((written_idx.size() != 0 && $random(seed) % 2 == 0) ? 1 : 0);
      drain();
    end
    report_test("random_ram");

    for (int i = 0; i < 16; i++) begin
      issue_request(i < 8, 4'hf, boundary_addr(i % 8), $random(seed));
      drain();
    end
    report_test("bank_bounds");

    repeat (20) begin
      issue_random(3);
      drain();
    end
    // RAM must be untouched by the unmapped writes
    for (int i = 0; i < 8; i++) begin
      issue_request(1'b0, 4'hf, boundary_addr(i), '0);
      drain();
    end
    report_test("unmapped");

    repeat (6) begin
      issue_random(2);
      drain();
    end
    for (int s = 0; s < 2; s++) begin
      @(posedge clk);
      boot_select <= 1'(s);
      strap_model = 1'(s);
      issue_request(1'b1, 4'hf, AO_PERIPH_BASE_ADDR + BOOT_SELECT_OFFSET, 32'hffff_ffff);
      drain();
      issue_request(1'b0, 4'hf, AO_PERIPH_BASE_ADDR + BOOT_SELECT_OFFSET, '0);
      drain();
    end
    issue_request(1'b1, 4'hf, AO_PERIPH_BASE_ADDR + EXIT_VALUE_OFFSET, $random(seed));
    drain();
    issue_request(1'b1, 4'b0101, AO_PERIPH_BASE_ADDR + EXIT_VALUE_OFFSET, $random(seed));
    drain();
    @(negedge clk);
    check_value("exit_value_o", exit_value_model, exit_value);
    check_value("exit_valid_o", 32'(1'b1), 32'(exit_valid));
    report_test("peripheral");

    repeat (250) issue_random($unsigned($random(seed)) % 4);
    drain();
    @(negedge clk);
    check_value("exit_valid_o", 32'(1'b1), 32'(exit_valid));
    report_test("back_to_back");

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mini_mcu_properties.sv ====
// Bus timing and exit flag properties, bound into mini_mcu
// assumes every target grants in the cycle the request is raised
`default_nettype none

module mini_mcu_properties
  import mini_mcu_pkg::*;
(
  input logic      clk_i,
  input logic      arst_n_i,
  input obi_req_t  bus_req_i,
  input obi_resp_t bus_resp_o,
  input logic      exit_valid_o
);

  logic accept;

  assign accept = bus_req_i.req && bus_resp_o.gnt;

  rvalid_after_accept: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) accept |=> bus_resp_o.rvalid
  ) else $error("rvalid missing one cycle after an accepted request");

  no_stray_rvalid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !accept |=> !bus_resp_o.rvalid
  ) else $error("rvalid without an accepted request in the cycle before");

  gnt_only_with_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) bus_resp_o.gnt |-> bus_req_i.req
  ) else $error("gnt high while req is low");

  // sticky until the next reset
  exit_valid_sticky: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) exit_valid_o |=> exit_valid_o
  ) else $error("exit_valid_o fell while out of reset");

endmodule

bind mini_mcu mini_mcu_properties props_i (.*);

`default_nettype wire

// ==== mini_mcu.sv ====
// Top level: one OBI master port onto RAM banks and always-on registers
// responses come one cycle after grant; unmapped addresses answer with err
`default_nettype none

module mini_mcu
  import mini_mcu_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_WORDS = 256
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  obi_req_t    bus_req_i,
  output obi_resp_t   bus_resp_o,
  input  logic        boot_select_i,
  output logic [31:0] exit_value_o,
  output logic        exit_valid_o
);

  localparam int SEL_W = target_sel_width(NUM_BANKS);

  obi_req_t  [NUM_BANKS-1:0] bank_req;
  obi_resp_t [NUM_BANKS-1:0] bank_resp;
  obi_req_t                  periph_req;
  obi_resp_t                 periph_resp;
  obi_resp_t                 mux_resp;
  logic                      bus_gnt;
  logic                      accept;
  logic      [SEL_W-1:0]     target_sel;

  obi_demux #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) obi_demux_i (
    .bus_req_i,
    .bus_gnt_o   (bus_gnt),
    .bank_req_o  (bank_req),
    .periph_req_o(periph_req),
    .accept_o    (accept),
    .target_sel_o(target_sel)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    ram_bank #(
      .BANK_WORDS(BANK_WORDS)
    ) ram_bank_i (
      .clk_i,
      .arst_n_i,
      .req_i (bank_req[b]),
      .resp_o(bank_resp[b])
    );
  end

  ao_peripheral ao_peripheral_i (
    .clk_i,
    .arst_n_i,
    .req_i (periph_req),
    .resp_o(periph_resp),
    .boot_select_i,
    .exit_value_o,
    .exit_valid_o
  );

  obi_resp_mux #(
    .NUM_BANKS(NUM_BANKS)
  ) obi_resp_mux_i (
    .clk_i,
    .arst_n_i,
    .accept_i     (accept),
    .target_sel_i (target_sel),
    .bank_resp_i  (bank_resp),
    .periph_resp_i(periph_resp),
    .resp_o       (mux_resp)
  );

  // grant is combinational from the demux, the rest is registered
  assign bus_resp_o = '{
    gnt:    bus_gnt,
    rvalid: mux_resp.rvalid,
    err:    mux_resp.err,
    rdata:  mux_resp.rdata
  };

endmodule

`default_nettype wire

// ==== ao_peripheral.sv ====
// Always-on registers: exit value/flag, scratch and boot strap readback
// exit_valid_o is sticky until reset; unknown offsets read zero
`default_nettype none

module ao_peripheral
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  obi_req_t    req_i,
  output obi_resp_t   resp_o,
  input  logic        boot_select_i,
  output logic [31:0] exit_value_o,
  output logic        exit_valid_o
);

  logic [11:0] reg_off;
  logic        wr_en;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic [31:0] scratch_q;
  logic [31:0] exit_value_q;
  logic        exit_valid_q;
  logic [31:0] rd_word;

  assign reg_off = req_i.addr[11:0];
  assign wr_en   = req_i.req && req_i.we;

  always_comb begin
    case (reg_off)
      EXIT_VALUE_OFFSET:  rd_word = exit_value_q;
      SCRATCH_OFFSET:     rd_word = scratch_q;
      BOOT_SELECT_OFFSET: rd_word = {31'b0, boot_select_i};
      default:            rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q     <= 1'b0;
      scratch_q    <= '0;
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (wr_en && reg_off == EXIT_VALUE_OFFSET) begin
        exit_value_q <= be_merge(exit_value_q, req_i.wdata, req_i.be);
        exit_valid_q <= 1'b1;
      end
      if (wr_en && reg_off == SCRATCH_OFFSET) begin
        scratch_q <= be_merge(scratch_q, req_i.wdata, req_i.be);
      end
    end
  end

  // read data, zero on writes
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : rd_word;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

`default_nettype wire

// ==== ram_bank.sv ====
// Single-port word RAM with byte enables, response one cycle after accept
// BANK_WORDS must be a power of two; contents are not cleared by reset
`default_nettype none

module ram_bank
  import mini_mcu_pkg::*;
#(
  parameter int BANK_WORDS = 256
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  localparam int AW = $clog2(BANK_WORDS);

  logic [31:0]   mem [BANK_WORDS];
  logic [AW-1:0] word_idx;
  logic [31:0]   rdata_q;
  logic          rvalid_q;

  assign word_idx = req_i.addr[AW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        mem[word_idx] <= be_merge(mem[word_idx], req_i.wdata, req_i.be);
        rdata_q       <= '0;
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign resp_o.gnt    = req_i.req;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.err    = 1'b0;
  assign resp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== obi_resp_mux.sv ====
// Response return path, one cycle after acceptance
// error responses are generated here, with zero data
`default_nettype none

module obi_resp_mux
  import mini_mcu_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   accept_i,
  input  logic [target_sel_width(NUM_BANKS)-1:0] target_sel_i,
  input  obi_resp_t [NUM_BANKS-1:0]              bank_resp_i,
  input  obi_resp_t                              periph_resp_i,
  output obi_resp_t                              resp_o
);

  localparam int SEL_W = target_sel_width(NUM_BANKS);
  localparam logic [SEL_W-1:0] PERIPH_SEL = SEL_W'(NUM_BANKS);
  localparam logic [SEL_W-1:0] ERR_SEL    = SEL_W'(NUM_BANKS + 1);

  logic             pending_q;
  logic [SEL_W-1:0] sel_q;

  // which target owes the next response
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
      sel_q     <= '0;
    end else begin
      pending_q <= accept_i;
      if (accept_i) begin
        sel_q <= target_sel_i;
      end
    end
  end

  always_comb begin
    resp_o = '0;
    if (pending_q) begin
      if (sel_q == PERIPH_SEL) begin
        resp_o.rvalid = periph_resp_i.rvalid;
        resp_o.rdata  = periph_resp_i.rdata;
      end else if (sel_q == ERR_SEL) begin
        resp_o.rvalid = 1'b1;
        resp_o.err    = 1'b1;
      end else begin
        for (int b = 0; b < NUM_BANKS; b++) begin
          if (sel_q == SEL_W'(b)) begin
            resp_o.rvalid = bank_resp_i[b].rvalid;
            resp_o.rdata  = bank_resp_i[b].rdata;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== obi_demux.sv ====
// Address decode for RAM banks, always-on window and the error target
// every request is granted; unmapped ones reach no target
`default_nettype none

module obi_demux
  import mini_mcu_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_WORDS = 256
) (
  input  obi_req_t                                  bus_req_i,
  output logic                                      bus_gnt_o,
  output obi_req_t [NUM_BANKS-1:0]                  bank_req_o,
  output obi_req_t                                  periph_req_o,
  output logic                                      accept_o,
  output logic [target_sel_width(NUM_BANKS)-1:0]    target_sel_o
);

  localparam int SEL_W = target_sel_width(NUM_BANKS);
  localparam logic [31:0] BANK_BYTES = 32'(BANK_WORDS * 4);
  localparam logic [31:0] RAM_BYTES  = 32'(NUM_BANKS * BANK_WORDS * 4);

  logic [31:0] ram_off;
  logic [31:0] periph_off;
  logic [31:0] bank_idx;
  logic        ram_hit;
  logic        periph_hit;

  assign ram_off    = bus_req_i.addr - RAM_BASE_ADDR;
  assign periph_off = bus_req_i.addr - AO_PERIPH_BASE_ADDR;
  assign ram_hit    = ram_off < RAM_BYTES;
  assign periph_hit = periph_off < AO_PERIPH_SIZE;
  assign bank_idx   = ram_off / BANK_BYTES;

  // all targets grant immediately
  assign bus_gnt_o = bus_req_i.req;
  assign accept_o  = bus_req_i.req;

  always_comb begin
    target_sel_o = SEL_W'(NUM_BANKS + 1);
    periph_req_o      = bus_req_i;
    periph_req_o.addr = periph_off;
    periph_req_o.req  = bus_req_i.req && periph_hit;
    if (periph_hit) begin
      target_sel_o = SEL_W'(NUM_BANKS);
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_req_o[b]      = bus_req_i;
      bank_req_o[b].addr = ram_off;
      bank_req_o[b].req  = 1'b0;
      if (ram_hit && bank_idx == 32'(b)) begin
        bank_req_o[b].req = bus_req_i.req;
        target_sel_o      = SEL_W'(b);
      end
    end
  end

endmodule

`default_nettype wire

// ==== mini_mcu_pkg.sv ====
// OBI request/response structs, memory map and always-on register offsets
// all accesses are word aligned; addr is a byte address
`default_nettype none

package mini_mcu_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  localparam logic [31:0] RAM_BASE_ADDR       = 32'h0000_0000;
  localparam logic [31:0] AO_PERIPH_BASE_ADDR = 32'h2000_0000;
  localparam logic [31:0] AO_PERIPH_SIZE      = 32'h0000_1000;

  // offsets inside the always-on window
  localparam logic [11:0] EXIT_VALUE_OFFSET  = 12'h000;
  localparam logic [11:0] SCRATCH_OFFSET     = 12'h004;
  localparam logic [11:0] BOOT_SELECT_OFFSET = 12'h008;

  // banks, then peripheral, then error target
  function automatic int unsigned target_sel_width(int unsigned num_banks);
    return $clog2(num_banks + 2);
  endfunction

  function automatic logic [31:0] be_merge(logic [31:0] old_word, logic [31:0] new_word,
                                           logic [3:0] be);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        merged[8*i+:8] = new_word[8*i+:8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire
